// ==== Makefile ====
# Verilator build and run of the scratchpad testbench

VERILATOR ?= verilator
TOP       ?= tb_scratch_top
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --binary --timing --assert -j 0 --timescale $(TIMESCALE)
SOURCES   := $(wildcard *.sv) $(wildcard *.svh)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; \
	  exit 1; \
	fi
	@if ! grep -q "TEST RESULT: PASS" $(LOG); then \
	  echo "simulation ended without a result, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== filelist.f ====
+incdir+.
scratch_pkg.sv
prio_arbiter.sv
scratch_bank.sv
resp_merge.sv
scratch_top.sv
tb_scratch_top.sv

// ==== prio_arbiter.sv ====
`timescale 1ns/100ps

module prio_arbiter #(
  parameter int unsigned NUM_REQ = 4
) (
  input  logic                                               clk_i,
  input  logic                                               rst_ni,
  // arbiter enable, low while the consumer is busy
  input  logic                                               en_i,
  input  logic [NUM_REQ-1:0]                                 req_i,
  output logic [NUM_REQ-1:0]                                 ack_o,
  output logic                                               vld_o,
  output logic [((NUM_REQ > 1) ? $clog2(NUM_REQ) : 1)-1:0]   idx_o
);

  localparam int unsigned SEL_W = (NUM_REQ > 1) ? $clog2(NUM_REQ) : 1;

  logic [NUM_REQ-1:0] gnt;
  logic [NUM_REQ-1:0] sel_oh;
  logic [SEL_W-1:0]   idx;
  logic [SEL_W-1:0]   lock_sel_q;
  logic               lock_q;

  // fixed priority, port 0 first
  // a port wins only if no lower-numbered port requests
  assign gnt[0] = req_i[0];
  for (genvar i = 1; i < NUM_REQ; i++) begin : gen_prio
    assign gnt[i] = req_i[i] & ~(|req_i[i-1:0]);
  end

  // one-hot to index, one or-tree per index bit
  for (genvar b = 0; b < SEL_W; b++) begin : gen_enc
    logic [NUM_REQ-1:0] bit_set;
    for (genvar i = 0; i < NUM_REQ; i++) begin : gen_term
      assign bit_set[i] = gnt[i] & (((i >> b) & 1) == 1);
    end
    assign idx[b] = |bit_set;
  end

  // while locked the frozen winner is shown instead of the live one
  assign idx_o = lock_q ? lock_sel_q : idx;

  always_comb begin
    sel_oh = gnt;
    if (lock_q) begin
      sel_oh = {{(NUM_REQ-1){1'b0}}, 1'b1} << lock_sel_q;
    end
  end

  // grant only when enabled and the selected port still requests
  assign ack_o = en_i ? (sel_oh & req_i) : '0;
  assign vld_o = |ack_o;

  // freeze the decision whenever requests wait on a disabled arbiter
  // the lock drops one cycle after en_i comes back
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lock_q     <= 1'b0;
      lock_sel_q <= '0;
    end else begin
      lock_q     <= (|req_i) & ~en_i;
      lock_sel_q <= idx_o;
    end
  end

  // at most one grant
  assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(ack_o));

  // a waiting winner is not replaced while disabled
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (!en_i && |req_i) |=> (idx_o == $past(idx_o)));

endmodule

// ==== resp_merge.sv ====
`timescale 1ns/100ps
`include "scratch_defines.svh"

module resp_merge (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  input  logic [`SCR_NUM_PORTS-1:0]                    req_i,
  // completions of bank 0 and bank 1
  input  scratch_pkg::bank_res_t                       res0_i,
  input  scratch_pkg::bank_res_t                       res1_i,
  output logic [`SCR_NUM_PORTS-1:0]                    ack_o,
  output scratch_pkg::scr_rsp_t [`SCR_NUM_PORTS-1:0]   rsp_o,
  // per port, high while that port's ack is high
  output logic [`SCR_NUM_PORTS-1:0]                    busy_o
);

  logic [`SCR_NUM_PORTS-1:0]                  hit0;
  logic [`SCR_NUM_PORTS-1:0]                  hit1;
  logic [`SCR_NUM_PORTS-1:0]                  ack_q;
  scratch_pkg::scr_rsp_t [`SCR_NUM_PORTS-1:0] rsp_q;

  // decode which port each bank completes this cycle
  for (genvar p = 0; p < `SCR_NUM_PORTS; p++) begin : gen_hit
    assign hit0[p] = res0_i.vld && (res0_i.port == scratch_pkg::port_idx_t'(p));
    assign hit1[p] = res1_i.vld && (res1_i.port == scratch_pkg::port_idx_t'(p));
  end

  // ack rises the cycle after a completion
  // falls the cycle after req is seen low
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q <= '0;
    end else begin
      for (int p = 0; p < `SCR_NUM_PORTS; p++) begin
        if (hit0[p] || hit1[p]) begin
          ack_q[p] <= 1'b1;
        end else if (ack_q[p] && !req_i[p]) begin
          ack_q[p] <= 1'b0;
        end
      end
    end
  end

  // read data held for as long as ack stays up
  always_ff @(posedge clk_i) begin
    for (int p = 0; p < `SCR_NUM_PORTS; p++) begin
      if (hit0[p]) begin
        rsp_q[p] <= res0_i.rsp;
      end else if (hit1[p]) begin
        rsp_q[p] <= res1_i.rsp;
      end
    end
  end

  assign ack_o  = ack_q;
  assign rsp_o  = rsp_q;
  // banks skip busy ports, so a held req is not served twice
  assign busy_o = ack_q;

  // a port has one request out, so only one bank can finish it
  assert property (@(posedge clk_i) disable iff (!rst_ni) !(|(hit0 & hit1)));

  // banks never complete a port whose ack is still up
  assert property (@(posedge clk_i) disable iff (!rst_ni) !(|((hit0 | hit1) & ack_q)));

endmodule

// ==== scratch_bank.sv ====
`timescale 1ns/100ps
`include "scratch_defines.svh"

module scratch_bank #(
  parameter int unsigned BANK_ID = 0
) (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  input  logic [`SCR_NUM_PORTS-1:0]                    req_i,
  input  scratch_pkg::scr_req_t [`SCR_NUM_PORTS-1:0]   req_data_i,
  // ports whose ack is currently high
  input  logic [`SCR_NUM_PORTS-1:0]                    busy_i,
  output scratch_pkg::bank_res_t                       res_o
);

  typedef enum logic {
    IDLE,
    ACCESS
  } state_e;

  state_e                             state_q;
  logic [`SCR_NUM_PORTS-1:0]          bank_hit;
  logic [`SCR_NUM_PORTS-1:0]          inflight;
  logic [`SCR_NUM_PORTS-1:0]          req_m;
  logic [`SCR_NUM_PORTS-1:0]          arb_ack;
  logic                               arb_vld;
  logic                               idle;
  scratch_pkg::port_idx_t             arb_idx;
  scratch_pkg::port_idx_t             port_q;
  scratch_pkg::scr_req_t              win_req;
  scratch_pkg::scr_req_t              cur_q;
  logic [`SCR_ADDR_W-2:0]             word;
  logic [`SCR_DATA_W-1:0]             mem_q [`SCR_BANK_WORDS];

  assign idle = (state_q == IDLE);

  // keep only ports addressing this bank
  for (genvar p = 0; p < `SCR_NUM_PORTS; p++) begin : gen_hit
    assign bank_hit[p] = (req_data_i[p].addr[0] == BANK_ID[0]);
  end

  // the port being served still holds req during ACCESS
  // its busy bit only shows up once ack rises
  assign inflight = idle ? '0 : ({{(`SCR_NUM_PORTS-1){1'b0}}, 1'b1} << port_q);

  assign req_m = req_i & bank_hit & ~busy_i & ~inflight;

  // enable low outside IDLE engages the lock-in
  prio_arbiter #(
    .NUM_REQ (`SCR_NUM_PORTS)
  ) i_arb (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .en_i   (idle),
    .req_i  (req_m),
    .ack_o  (arb_ack),
    .vld_o  (arb_vld),
    .idx_o  (arb_idx)
  );

  // and-or mux of the payloads by the one-hot grant
  always_comb begin
    win_req = '0;
    for (int p = 0; p < `SCR_NUM_PORTS; p++) begin
      if (arb_ack[p]) begin
        win_req = win_req | req_data_i[p];
      end
    end
  end

  // IDLE -> ACCESS on a grant, ACCESS lasts exactly one cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      port_q  <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (arb_vld) begin
            state_q <= ACCESS;
            port_q  <= arb_idx;
          end
        end
        default: begin
          state_q <= IDLE;
        end
      endcase
    end
  end

  // winner's payload, taken on the grant edge
  always_ff @(posedge clk_i) begin
    if (idle && arb_vld) begin
      cur_q <= win_req;
    end
  end

  // word index inside the bank, bank bit dropped
  assign word = cur_q.addr[`SCR_ADDR_W-1:1];

  // storage, write lands at the end of the ACCESS cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int w = 0; w < `SCR_BANK_WORDS; w++) begin
        mem_q[w] <= '0;
      end
    end else if (!idle && cur_q.we) begin
      mem_q[word] <= cur_q.wdata;
    end
  end

  // result is the old word, presented during ACCESS
  assign res_o.vld       = !idle;
  assign res_o.port      = port_q;
  assign res_o.rsp.rdata = mem_q[word];

  // one completion per access, never back to back
  assert property (@(posedge clk_i) disable iff (!rst_ni) res_o.vld |=> !res_o.vld);

endmodule

// ==== scratch_defines.svh ====
`ifndef SCRATCH_DEFINES_SVH
`define SCRATCH_DEFINES_SVH

// number of requesters sharing the scratchpad
`define SCR_NUM_PORTS 4

// word address width
// bit 0 picks the bank, the upper bits pick the word inside it
`define SCR_ADDR_W 6

// data word width
`define SCR_DATA_W 16

// words held by each of the two banks
// must match 2**(SCR_ADDR_W-1)
`define SCR_BANK_WORDS 32

`endif

// ==== scratch_pkg.sv ====
`include "scratch_defines.svh"

package scratch_pkg;

  // index of one requester port
  typedef logic [$clog2(`SCR_NUM_PORTS)-1:0] port_idx_t;

  // request payload, held stable by the port while its req is high
  typedef struct packed {
    // write enable, low for a read
    logic                   we;
    // word address, bit 0 selects the bank
    logic [`SCR_ADDR_W-1:0] addr;
    // write data, ignored on reads
    logic [`SCR_DATA_W-1:0] wdata;
  } scr_req_t;

  // response returned with ack
  // a write also returns the word as it was before the write
  typedef struct packed {
    logic [`SCR_DATA_W-1:0] rdata;
  } scr_rsp_t;

  // one bank's completion, valid for a single cycle
  typedef struct packed {
    logic      vld;
    // port the completion belongs to
    port_idx_t port;
    scr_rsp_t  rsp;
  } bank_res_t;

endpackage

// ==== scratch_top.sv ====
`timescale 1ns/100ps
`include "scratch_defines.svh"

module scratch_top (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  // four-phase request per port
  input  logic [`SCR_NUM_PORTS-1:0]                    req_i,
  input  scratch_pkg::scr_req_t [`SCR_NUM_PORTS-1:0]   req_data_i,
  output logic [`SCR_NUM_PORTS-1:0]                    ack_o,
  output scratch_pkg::scr_rsp_t [`SCR_NUM_PORTS-1:0]   rsp_o
);

  logic [`SCR_NUM_PORTS-1:0] busy;
  scratch_pkg::bank_res_t    res0;
  scratch_pkg::bank_res_t    res1;

  // even word addresses
  scratch_bank #(
    .BANK_ID (0)
  ) i_bank0 (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .req_i      (req_i),
    .req_data_i (req_data_i),
    .busy_i     (busy),
    .res_o      (res0)
  );

  // odd word addresses
  scratch_bank #(
    .BANK_ID (1)
  ) i_bank1 (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .req_i      (req_i),
    .req_data_i (req_data_i),
    .busy_i     (busy),
    .res_o      (res1)
  );

  // both banks may complete in the same cycle for different ports
  resp_merge i_merge (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .req_i  (req_i),
    .res0_i (res0),
    .res1_i (res1),
    .ack_o  (ack_o),
    .rsp_o  (rsp_o),
    .busy_o (busy)
  );

endmodule

// ==== tb_scratch_top.sv ====
`timescale 1ns/100ps
`include "scratch_defines.svh"

module tb_scratch_top;

  localparam int NP       = `SCR_NUM_PORTS;
  localparam int NUM_ENT  = 12;
  localparam int TIMEOUT  = 50;
  localparam int NUM_RAND = 16;

  // one table row, ports in mask start together
  typedef struct packed {
    logic [NP-1:0]                      mask;
    // gated ports wait for the ack of gate_port before raising req
    logic [NP-1:0]                      gate;
    scratch_pkg::port_idx_t             gate_port;
    // expected data taken from the shadow memory
    logic [NP-1:0]                      comp;
    logic                               chk_lat;
    logic [2:0]                         ord_n;
    scratch_pkg::port_idx_t [NP-1:0]    ord;
    scratch_pkg::scr_req_t [NP-1:0]     req;
    scratch_pkg::scr_rsp_t [NP-1:0]     exp;
  } entry_t;

  logic                              clk_i;
  logic                              rst_ni;
  logic [NP-1:0]                     req_i;
  scratch_pkg::scr_req_t [NP-1:0]    req_data_i;
  logic [NP-1:0]                     ack_o;
  scratch_pkg::scr_rsp_t [NP-1:0]    rsp_o;

  entry_t                            tbl [NUM_ENT];
  string                             tname [NUM_ENT];
  logic [`SCR_DATA_W-1:0]            shadow [2**`SCR_ADDR_W];
  scratch_pkg::scr_rsp_t             got [NP];
  int                                lat [NP];
  scratch_pkg::port_idx_t            ack_order [$];
  int                                errors;
  int                                failed;
  int                                timeouts;

  scratch_top dut (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .req_i      (req_i),
    .req_data_i (req_data_i),
    .ack_o      (ack_o),
    .rsp_o      (rsp_o)
  );

  initial clk_i = 1'b0;
  always #50 clk_i = ~clk_i;

  task automatic check_rsp(input string name, input int port,
                           input scratch_pkg::scr_rsp_t want, input scratch_pkg::scr_rsp_t act);
    if (act !== want) begin
      $display("[ERROR] %s port %0d: expected %h, actual %h", name, port, want.rdata, act.rdata);
      errors++;
    end
  endtask

  task automatic check_order(input string name, input int pos,
                             input scratch_pkg::port_idx_t want, input scratch_pkg::port_idx_t act);
    if (act !== want) begin
      $display("[ERROR] %s ack #%0d: expected port %0d, actual port %0d", name, pos, want, act);
      errors++;
    end
  endtask

  task automatic check_latency(input string name, input int port, input int want, input int act);
    if (act != want) begin
      $display("[ERROR] %s port %0d latency: expected %0d, actual %0d", name, port, want, act);
      errors++;
    end
  endtask

  // fills one port of a row
  function automatic entry_t set_port(input entry_t e, input int port, input bit we,
                                      input int addr, input int data, input bit comp,
                                      input int want);
    entry_t r;
    r = e;
    r.mask[port]          = 1'b1;
    r.req[port].we        = we;
    r.req[port].addr      = addr[`SCR_ADDR_W-1:0];
    r.req[port].wdata     = data[`SCR_DATA_W-1:0];
    r.comp[port]          = comp;
    r.exp[port].rdata     = want[`SCR_DATA_W-1:0];
    return r;
  endfunction

  function automatic void build_table();
    entry_t e;
    // first reads after reset, two ports per bank
    e = '0;
    for (int p = 0; p < NP; p++) begin
      e = set_port(e, p, 1'b0, p, 0, 1'b0, 0);
    end
    tbl[0]   = e;
    tname[0] = "reset_read";
    // write returns the old word, read returns the new one
    for (int p = 0; p < NP; p++) begin
      e = '0;
      e.chk_lat = 1'b1;
      tbl[1 + 2*p]   = set_port(e, p, 1'b1, 32 + 5*p, 'hc0de + 'h0101*p, 1'b1, 0);
      tname[1 + 2*p] = $sformatf("write_port%0d", p);
      tbl[2 + 2*p]   = set_port(e, p, 1'b0, 32 + 5*p, 0, 1'b0, 'hc0de + 'h0101*p);
      tname[2 + 2*p] = $sformatf("read_port%0d", p);
    end
    // even and odd bank at once
    e = '0;
    e.chk_lat = 1'b1;
    e = set_port(e, 0, 1'b1, 10, 'h1234, 1'b1, 0);
    e = set_port(e, 3, 1'b0, 37, 0, 1'b1, 0);
    tbl[9]   = e;
    tname[9] = "bank_parallel";
    // three ports on bank 0, lowest index first
    e = '0;
    e = set_port(e, 1, 1'b0, 32, 0, 1'b1, 0);
    e = set_port(e, 2, 1'b0, 42, 0, 1'b1, 0);
    e = set_port(e, 3, 1'b0, 10, 0, 1'b1, 0);
    e.ord_n  = 3'd3;
    e.ord[0] = scratch_pkg::port_idx_t'(1);
    e.ord[1] = scratch_pkg::port_idx_t'(2);
    e.ord[2] = scratch_pkg::port_idx_t'(3);
    tbl[10]   = e;
    tname[10] = "priority";
    // port 0 shows up while port 3 is already the frozen winner
    e = '0;
    e = set_port(e, 2, 1'b0, 32, 0, 1'b1, 0);
    e = set_port(e, 3, 1'b0, 42, 0, 1'b1, 0);
    e = set_port(e, 0, 1'b0, 10, 0, 1'b1, 0);
    e.gate[0]   = 1'b1;
    e.gate_port = scratch_pkg::port_idx_t'(2);
    e.ord_n     = 3'd3;
    e.ord[0]    = scratch_pkg::port_idx_t'(2);
    e.ord[1]    = scratch_pkg::port_idx_t'(3);
    e.ord[2]    = scratch_pkg::port_idx_t'(0);
    tbl[11]   = e;
    tname[11] = "lock_in";
  endfunction

  // four-phase sequence on one port, all steps on the falling edge
  task automatic drive_port(input int port, input scratch_pkg::scr_req_t rq, input bit gated,
                            input int gp, input bit hold);
    int n;
    bit ok;
    n  = 0;
    ok = 1'b1;
    if (gated) begin
      while (!ack_o[gp] && n < TIMEOUT) begin
        @(negedge clk_i);
        n++;
      end
      if (!ack_o[gp]) begin
        $display("port %0d gave up waiting for the ack of port %0d", port, gp);
        timeouts++;
        ok = 1'b0;
      end
    end
    if (ok) begin
      req_data_i[port] = rq;
      req_i[port]      = 1'b1;
      n = 0;
      while (!ack_o[port] && n < TIMEOUT) begin
        @(negedge clk_i);
        n++;
      end
      lat[port] = n;
      got[port] = rsp_o[port];
      if (!ack_o[port]) begin
        $display("port %0d saw no ack within %0d cycles", port, TIMEOUT);
        timeouts++;
        req_i[port] = 1'b0;
      end else begin
        ack_order.push_back(scratch_pkg::port_idx_t'(port));
        // a held req keeps the ack up
        if (!hold) begin
          req_i[port] = 1'b0;
          n = 0;
          while (ack_o[port] && n < TIMEOUT) begin
            @(negedge clk_i);
            n++;
          end
          if (ack_o[port]) begin
            $display("port %0d ack stayed high after req dropped", port);
            timeouts++;
          end
        end
      end
    end
  endtask

  task automatic apply_entry(input int idx);
    entry_t                en;
    scratch_pkg::scr_rsp_t want [NP];
    int                    err0;
    en   = tbl[idx];
    err0 = errors + timeouts;
    ack_order.delete();
    // addresses differ inside a row, so old words come from the shadow as it is now
    for (int p = 0; p < NP; p++) begin
      want[p] = en.comp[p] ? scratch_pkg::scr_rsp_t'(shadow[en.req[p].addr]) : en.exp[p];
    end
    fork
      if (en.mask[0]) drive_port(0, en.req[0], en.gate[0], int'(en.gate_port), 1'b0);
      if (en.mask[1]) drive_port(1, en.req[1], en.gate[1], int'(en.gate_port), 1'b0);
      if (en.mask[2]) drive_port(2, en.req[2], en.gate[2], int'(en.gate_port), 1'b0);
      if (en.mask[3]) drive_port(3, en.req[3], en.gate[3], int'(en.gate_port), 1'b0);
    join
    for (int p = 0; p < NP; p++) begin
      if (en.mask[p]) begin
        check_rsp(tname[idx], p, want[p], got[p]);
        if (en.chk_lat && !en.gate[p]) begin
          check_latency(tname[idx], p, 2, lat[p]);
        end
        if (en.req[p].we) begin
          shadow[en.req[p].addr] = en.req[p].wdata;
        end
      end
    end
    if (ack_order.size() < int'(en.ord_n)) begin
      $display("%s: only %0d acks seen for the order check", tname[idx], ack_order.size());
      errors++;
    end else begin
      for (int i = 0; i < int'(en.ord_n); i++) begin
        check_order(tname[idx], i, en.ord[i], ack_order[i]);
      end
    end
    if (errors + timeouts == err0) begin
      $display("[ok]   %s", tname[idx]);
    end else begin
      $display("[fail] %s", tname[idx]);
      failed++;
    end
  endtask

  // port 1 holds its ack while the others run random traffic
  task automatic hold_and_mix();
    scratch_pkg::scr_req_t rq;
    scratch_pkg::scr_rsp_t want;
    int unsigned           rnd;
    int                    err0;
    int                    port;
    int                    n;
    err0 = errors + timeouts;
    rq   = '{we: 1'b0, addr: 6'd5, wdata: '0};
    want = scratch_pkg::scr_rsp_t'(shadow[5]);
    drive_port(1, rq, 1'b0, 0, 1'b1);
    check_rsp("backpressure_hold", 1, want, got[1]);
    for (int i = 0; i < NUM_RAND && timeouts == 0; i++) begin
      rnd  = $urandom;
      port = int'(rnd % 3);
      if (port > 0) begin
        port++;
      end
      rnd      = $urandom;
      rq.we    = rnd[0];
      rq.addr  = rnd[`SCR_ADDR_W:1];
      rnd      = $urandom;
      rq.wdata = rnd[`SCR_DATA_W-1:0];
      want     = scratch_pkg::scr_rsp_t'(shadow[rq.addr]);
      drive_port(port, rq, 1'b0, 0, 1'b0);
      check_rsp("backpressure_mix", port, want, got[port]);
      check_latency("backpressure_mix", port, 2, lat[port]);
      if (rq.we) begin
        shadow[rq.addr] = rq.wdata;
      end
      if (!ack_o[1]) begin
        $display("port 1 ack dropped while its req was still held");
        errors++;
      end
    end
    // release port 1
    req_i[1] = 1'b0;
    n = 0;
    while (ack_o[1] && n < TIMEOUT) begin
      @(negedge clk_i);
      n++;
    end
    if (ack_o[1]) begin
      $display("port 1 ack stayed high after its req was released");
      timeouts++;
    end
    if (errors + timeouts == err0) begin
      $display("[ok]   backpressure");
    end else begin
      $display("[fail] backpressure");
      failed++;
    end
  endtask

  initial begin
    void'($urandom(32'ha673d598));
    errors     = 0;
    failed     = 0;
    timeouts   = 0;
    rst_ni     = 1'b0;
    req_i      = '0;
    req_data_i = '0;
    for (int a = 0; a < 2**`SCR_ADDR_W; a++) begin
      shadow[a] = '0;
    end
    build_table();
    repeat (3) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    // no port may come out of reset acknowledged
    if (ack_o !== '0) begin
      $display("[ERROR] reset_ack: expected %b, actual %b", {NP{1'b0}}, ack_o);
      errors++;
      $display("[fail] reset_ack");
      failed++;
    end else begin
      $display("[ok]   reset_ack");
    end
    for (int e = 0; e < NUM_ENT && timeouts == 0; e++) begin
      apply_entry(e);
    end
    if (timeouts == 0) begin
      hold_and_mix();
    end
    $display("summary: %0d tests, %0d failed, %0d errors, %0d timeouts",
             NUM_ENT + 2, failed, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule
